// ==== cpu_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// CPU shared definitions: ISA field layout, opcodes, ALU operations
// and the structs carried between pipeline stages
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package cpu_pkg;

    localparam int xlen = 32;                // Data and address width

    typedef logic [4:0] reg_addr_t;          // Register number

    localparam reg_addr_t link_reg = 5'd31;  // jal writes its return address here

    // Top five bits of every instruction
    typedef enum logic [4:0] {
        op_alu  = 5'd0,
        op_j    = 5'd1,
        op_bne  = 5'd2,
        op_jal  = 5'd3,
        op_addi = 5'd5,
        op_blt  = 5'd6,
        op_sw   = 5'd7,
        op_lw   = 5'd8
    } opcode_t;

    typedef enum logic [4:0] {
        alu_add = 5'd0,
        alu_sub = 5'd1,
        alu_and = 5'd2,
        alu_or  = 5'd3,
        alu_sll = 5'd4,
        alu_sra = 5'd5
    } alu_op_t;

    typedef struct packed {
        opcode_t   opcode;   // [31:27]
        reg_addr_t rd;       // [26:22]
        reg_addr_t rs;       // [21:17]
        reg_addr_t rt;       // [16:12]
        logic [4:0] shamt;   // [11:7]
        alu_op_t   alu_op;   // [6:2]
        logic [1:0] spare;
    } r_fmt_t;

    typedef struct packed {
        opcode_t    opcode;
        reg_addr_t  rd;
        reg_addr_t  rs;
        logic [16:0] imm;    // Signed, also the low bits of a jump target
    } i_fmt_t;

    // Same word, two views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_t;

    typedef struct packed {
        logic      writes_reg;
        reg_addr_t dest;            // rd, link_reg for jal; store/branch source
        logic      reads_rs;
        logic      reads_rt_field;  // Second source is rt (R-format only)
        logic      use_imm;
        alu_op_t   alu_op;
        logic      is_load;
        logic      is_store;
        logic      is_bne;
        logic      is_blt;
        logic      is_jal;
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        instr_t          instr;
    } fd_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        instr_t          instr;
        ctrl_t           ctrl;
        logic [xlen-1:0] a;     // Register file value of rs
        logic [xlen-1:0] b;     // Register file value of rt or rd
    } dx_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        ctrl_t           ctrl;
        logic [xlen-1:0] result;
        logic [xlen-1:0] store_data;
    } xm_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [xlen-1:0] result;
        logic [xlen-1:0] load_data;
    } mw_t;

    typedef struct packed {
        logic            we;
        reg_addr_t       dest;
        logic [xlen-1:0] data;
    } wb_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// ==== alu.sv ====
////////////////////////////////////////////////////////////////////////////
// ALU with the not-equal and signed less-than flags for branches
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    input  cpu_pkg::alu_op_t op,
    input  logic [4:0]       shamt,
    output logic [31:0]      result,
    output logic             not_equal,
    output logic             less_than
);

    logic [31:0] diff;
    logic        sub_ovf;

    // Flags come off the subtractor, branches select sub in decode
    assign diff      = a - b;
    assign sub_ovf   = (a[31] ^ b[31]) & (a[31] ^ diff[31]);
    assign not_equal = |diff;
    assign less_than = diff[31] ^ sub_ovf;   // Signed a < b

    always_comb begin
        case (op)
            cpu_pkg::alu_add: result = a + b;
            cpu_pkg::alu_sub: result = diff;
            cpu_pkg::alu_and: result = a & b;
            cpu_pkg::alu_or:  result = a | b;
            cpu_pkg::alu_sll: result = a << shamt;
            cpu_pkg::alu_sra: result = $signed(a) >>> shamt;  // Sign fill
            default:          result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== register_file.sv ====
////////////////////////////////////////////////////////////////////////////
// 32 x 32 register file, two read ports with write-through, r0 fixed at 0
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic               clock,
    input  logic               rst_n,
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    output logic [31:0]        rs_data,
    output logic [31:0]        rt_data,
    input  cpu_pkg::wb_t       wb
);

    logic [31:0] regs [31:1];   // No storage behind r0

    // Same-cycle writeback passes straight to the reader
    always_comb begin
        if (rs_addr == '0) begin
            rs_data = '0;
        end else if (wb.we && wb.dest == rs_addr) begin
            rs_data = wb.data;
        end else begin
            rs_data = regs[rs_addr];
        end
        if (rt_addr == '0) begin
            rt_data = '0;
        end else if (wb.we && wb.dest == rt_addr) begin
            rt_data = wb.data;
        end else begin
            rt_data = regs[rt_addr];
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && wb.dest != '0) begin
            regs[wb.dest] <= wb.data;        // Writes to r0 dropped
        end
    end

endmodule

`default_nettype wire

// ==== fetch_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Fetch: program counter, j/jal predecode, branch redirect, F/D register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic               clock,
    input  logic               rst_n,
    output logic [31:0]        imem_addr,
    input  cpu_pkg::instr_t    imem_data,
    input  logic               stall,
    input  cpu_pkg::redirect_t redirect,
    output cpu_pkg::fd_t       fd
);

    logic [31:0] pc;
    logic [31:0] jump_target;
    logic        is_jump;        // j or jal seen on the fetch bus

    assign imem_addr = pc;

    // Jumps resolve here so no slot is lost
    assign is_jump = (imem_data.i_fmt.opcode == cpu_pkg::op_j) ||
                     (imem_data.i_fmt.opcode == cpu_pkg::op_jal);
    assign jump_target = {5'd0, imem_data.i_fmt.rd, imem_data.i_fmt.rs,
                          imem_data.i_fmt.imm};   // Low 27 bits, zero extended

    // PC priority: redirect, stall, jump, sequential
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (redirect.valid) begin
            pc <= redirect.target;
        end else if (!stall) begin
            pc <= is_jump ? jump_target : pc + 32'd1;
        end
    end

    // F/D register
    always_ff @(posedge clock) begin
        if (!rst_n || redirect.valid) begin
            fd <= '0;                      // Bubble, all-zero word
        end else if (!stall) begin
            fd.pc    <= pc;
            fd.instr <= imem_data;
        end
    end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Decode: control generation, register reads, load-use stall, D/X register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic               clock,
    input  logic               rst_n,
    input  cpu_pkg::fd_t       fd,
    input  cpu_pkg::redirect_t redirect,
    output cpu_pkg::reg_addr_t rs_addr,
    output cpu_pkg::reg_addr_t rt_addr,
    input  logic [31:0]        rs_data,
    input  logic [31:0]        rt_data,
    output logic               stall,
    output cpu_pkg::dx_t       dx
);

    cpu_pkg::ctrl_t ctrl;
    logic           rd_as_b;     // Store data or branch compare comes from rd
    logic           reads_b;
    logic           rs_hit, b_hit;

    always_comb begin
        ctrl        = '0;
        ctrl.dest   = fd.instr.r_fmt.rd;
        ctrl.alu_op = cpu_pkg::alu_add;     // Address and addi math
        case (fd.instr.r_fmt.opcode)
            cpu_pkg::op_alu: begin
                ctrl.writes_reg     = 1'b1;
                ctrl.reads_rs       = 1'b1;
                ctrl.reads_rt_field = 1'b1;
                ctrl.alu_op         = fd.instr.r_fmt.alu_op;
            end
            cpu_pkg::op_addi: begin
                ctrl.writes_reg = 1'b1;
                ctrl.reads_rs   = 1'b1;
                ctrl.use_imm    = 1'b1;
            end
            cpu_pkg::op_lw: begin
                ctrl.writes_reg = 1'b1;
                ctrl.reads_rs   = 1'b1;
                ctrl.use_imm    = 1'b1;
                ctrl.is_load    = 1'b1;
            end
            cpu_pkg::op_sw: begin
                ctrl.reads_rs = 1'b1;
                ctrl.use_imm  = 1'b1;
                ctrl.is_store = 1'b1;            // dest names the data register
            end
            cpu_pkg::op_bne: begin
                ctrl.reads_rs = 1'b1;
                ctrl.alu_op   = cpu_pkg::alu_sub; // Compare through subtract
                ctrl.is_bne   = 1'b1;
            end
            cpu_pkg::op_blt: begin
                ctrl.reads_rs = 1'b1;
                ctrl.alu_op   = cpu_pkg::alu_sub;
                ctrl.is_blt   = 1'b1;
            end
            cpu_pkg::op_jal: begin
                ctrl.writes_reg = 1'b1;
                ctrl.dest       = cpu_pkg::link_reg;
                ctrl.is_jal     = 1'b1;
            end
            default: ;                           // j and bubbles do nothing here
        endcase
    end

    assign rd_as_b = ctrl.is_store | ctrl.is_bne | ctrl.is_blt;
    assign reads_b = ctrl.reads_rt_field | rd_as_b;
    assign rs_addr = fd.instr.r_fmt.rs;
    assign rt_addr = rd_as_b ? fd.instr.r_fmt.rd : fd.instr.r_fmt.rt;

    // Load in execute feeding this instruction: hold one cycle
    assign rs_hit = ctrl.reads_rs && (rs_addr == dx.ctrl.dest);
    // Store data is patched later in the memory stage
    assign b_hit  = reads_b && !ctrl.is_store && (rt_addr == dx.ctrl.dest);
    assign stall  = dx.ctrl.is_load && (dx.ctrl.dest != '0) && (rs_hit || b_hit);

    always_ff @(posedge clock) begin
        if (!rst_n || stall || redirect.valid) begin
            dx <= '0;
        end else begin
            dx.pc    <= fd.pc;
            dx.instr <= fd.instr;
            dx.ctrl  <= ctrl;
            dx.a     <= rs_data;
            dx.b     <= rt_data;
        end
    end

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Execute: operand forwarding, immediate select, ALU, branch resolution
// and the X/M register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                clock,
    input  logic                rst_n,
    input  cpu_pkg::dx_t        dx,
    input  cpu_pkg::wb_t        wb,
    output cpu_pkg::xm_t        xm,
    output cpu_pkg::redirect_t  redirect
);

    cpu_pkg::reg_addr_t rs_src, b_src;
    logic [31:0]        op_a, fwd_b, op_b;
    logic [31:0]        imm_sext;
    logic [31:0]        alu_result;
    logic [31:0]        pc_plus1;
    logic               not_equal, less_than;
    logic               taken;

    // Newest value wins: memory stage, then writeback, then register file
    function automatic logic [31:0] forward(
        input cpu_pkg::reg_addr_t src,
        input logic [31:0]        rf_val,
        input cpu_pkg::xm_t       mem,
        input cpu_pkg::wb_t       wr
    );
        if (mem.ctrl.writes_reg && mem.ctrl.dest != '0 && mem.ctrl.dest == src) begin
            return mem.result;
        end else if (wr.we && wr.dest != '0 && wr.dest == src) begin
            return wr.data;
        end
        return rf_val;
    endfunction

    assign rs_src = dx.instr.r_fmt.rs;
    assign b_src  = dx.ctrl.reads_rt_field ? dx.instr.r_fmt.rt : dx.instr.r_fmt.rd;

    assign op_a  = forward(rs_src, dx.a, xm, wb);
    assign fwd_b = forward(b_src, dx.b, xm, wb);

    assign imm_sext = {{15{dx.instr.i_fmt.imm[16]}}, dx.instr.i_fmt.imm};
    assign op_b     = dx.ctrl.use_imm ? imm_sext : fwd_b;   // addi, lw, sw

    alu i_alu (
        .a         (op_a),
        .b         (op_b),
        .op        (dx.ctrl.alu_op),
        .shamt     (dx.instr.r_fmt.shamt),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    assign pc_plus1 = dx.pc + 32'd1;

    // blt: rd < rs, i.e. rs - rd neither negative nor zero
    assign taken = (dx.ctrl.is_bne && not_equal) ||
                   (dx.ctrl.is_blt && not_equal && !less_than);

    // Predict-not-taken, fix up on a taken branch
    assign redirect.valid  = taken;
    assign redirect.target = pc_plus1 + imm_sext;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            xm <= '0;
        end else begin
            xm.pc         <= dx.pc;
            xm.ctrl       <= dx.ctrl;
            xm.result     <= dx.ctrl.is_jal ? pc_plus1 : alu_result; // Link value
            xm.store_data <= fwd_b;
        end
    end

endmodule

`default_nettype wire

// ==== mem_wb_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Memory and writeback: data memory drive, store-data forwarding,
// M/W register and the writeback select
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
    input  logic          clock,
    input  logic          rst_n,
    input  cpu_pkg::xm_t  xm,
    output logic [31:0]   dmem_addr,
    output logic [31:0]   dmem_wdata,
    output logic          dmem_wren,
    input  logic [31:0]   dmem_rdata,
    output cpu_pkg::wb_t  wb
);

    cpu_pkg::mw_t mw;
    logic         store_fwd;   // Load in writeback feeds this store

    assign dmem_addr = xm.result;          // Address from the ALU add
    assign dmem_wren = xm.ctrl.is_store;

    // For a store, ctrl.dest names its data register
    assign store_fwd = xm.ctrl.is_store && mw.ctrl.is_load && mw.ctrl.writes_reg &&
                       (mw.ctrl.dest != '0) && (mw.ctrl.dest == xm.ctrl.dest);
    assign dmem_wdata = store_fwd ? wb.data : xm.store_data;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            mw <= '0;
        end else begin
            mw.ctrl      <= xm.ctrl;
            mw.result    <= xm.result;
            mw.load_data <= dmem_rdata;
        end
    end

    // Writeback
    assign wb.we   = mw.ctrl.writes_reg;
    assign wb.dest = mw.ctrl.dest;
    assign wb.data = mw.ctrl.is_load ? mw.load_data : mw.result;

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Five-stage pipelined CPU core, stages and register file wired together
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  logic              clock,
    input  logic              rst_n,
    output logic [31:0]       imem_addr,
    input  cpu_pkg::instr_t   imem_data,   // Combinational instruction memory
    output logic [31:0]       dmem_addr,
    output logic [31:0]       dmem_wdata,
    output logic              dmem_wren,
    input  logic [31:0]       dmem_rdata
);

    cpu_pkg::fd_t       fd;
    cpu_pkg::dx_t       dx;
    cpu_pkg::xm_t       xm;
    cpu_pkg::wb_t       wb;
    cpu_pkg::redirect_t redirect;   // Taken branch from execute
    cpu_pkg::reg_addr_t rs_addr, rt_addr;
    logic [31:0]        rs_data, rt_data;
    logic               stall;      // Load-use hold

    fetch_stage i_fetch_stage (
        .clock     (clock),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .stall     (stall),
        .redirect  (redirect),
        .fd        (fd)
    );

    decode_stage i_decode_stage (
        .clock    (clock),
        .rst_n    (rst_n),
        .fd       (fd),
        .redirect (redirect),
        .rs_addr  (rs_addr),
        .rt_addr  (rt_addr),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .stall    (stall),
        .dx       (dx)
    );

    register_file i_register_file (
        .clock   (clock),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb      (wb)
    );

    execute_stage i_execute_stage (
        .clock    (clock),
        .rst_n    (rst_n),
        .dx       (dx),
        .wb       (wb),
        .xm       (xm),
        .redirect (redirect)
    );

    mem_wb_stage i_mem_wb_stage (
        .clock      (clock),
        .rst_n      (rst_n),
        .xm         (xm),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wren  (dmem_wren),
        .dmem_rdata (dmem_rdata),
        .wb         (wb)
    );

endmodule

`default_nettype wire

// ==== tb_cpu_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the pipelined CPU: models both memories, runs the program
// from the pattern file and checks every store against the expected list
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;

    logic            clock;
    logic            rst_n;
    logic [31:0]     imem_addr;
    cpu_pkg::instr_t imem_data;
    logic [31:0]     dmem_addr;
    logic [31:0]     dmem_wdata;
    logic            dmem_wren;
    logic [31:0]     dmem_rdata;

    logic [31:0] pat  [0:255];   // Raw pattern file contents
    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];

    int prog_len;                // Program words
    int exp_count;               // Expected stores
    int exp_base;                // First expected triple in pat
    int store_cnt    = 0;        // Stores seen after reset
    int value_errs   = 0;
    int extra_errs   = 0;
    int count_errs   = 0;
    int reset_errs   = 0;
    int file_errs    = 0;
    int timeout_errs = 0;

    cpu_top i_cpu_top (
        .clock      (clock),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wren  (dmem_wren),
        .dmem_rdata (dmem_rdata)
    );

    always #2 clock = ~clock;    // 4 ns period

    // Behavior label carried in the third column of each expected store
    function automatic string test_name(input logic [31:0] id);
        case (id)
            32'd1:   return "alu_forwarding";
            32'd2:   return "load_use";
            32'd3:   return "branch";
            32'd4:   return "jump";
            32'd5:   return "reg_zero";
            default: return "unknown";
        endcase
    endfunction

    // Compare one store against the next expected (address, data) pair
    task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] exp_addr;
        logic [31:0] exp_data;
        string       name;
        assert (store_cnt < exp_count) else begin
            extra_errs++;
            $display("Error: unexpected store number %0d to address %h with data %h",
                     store_cnt, addr, data);
        end
        if (store_cnt < exp_count) begin
            exp_addr = pat[exp_base + 3 * store_cnt];
            exp_data = pat[exp_base + 3 * store_cnt + 1];
            name     = test_name(pat[exp_base + 3 * store_cnt + 2]);
            assert (addr === exp_addr) else begin
                value_errs++;
                $display("Fail %s store %0d address: expected %h, actual %h",
                         name, store_cnt, exp_addr, addr);
            end
            assert (data === exp_data) else begin
                value_errs++;
                $display("Fail %s store %0d data: expected %h, actual %h",
                         name, store_cnt, exp_data, data);
            end
        end
        store_cnt++;
    endtask

    // Closing report, ends the simulation
    task automatic finish_run();
        int total;
        total = value_errs + extra_errs + count_errs + reset_errs + file_errs
                + timeout_errs;
        $display("Errors: %0d value, %0d extra store, %0d count, %0d reset, %0d file, %0d timeout",
                 value_errs, extra_errs, count_errs, reset_errs, file_errs, timeout_errs);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // Limit scales with program length
    task automatic run_watchdog();
        int limit;
        limit = 20 * prog_len + 100;
        repeat (limit) @(posedge clock);
        timeout_errs++;
        $display("Error: watchdog expired after %0d cycles with %0d of %0d stores seen",
                 limit, store_cnt, exp_count);
        finish_run();
    endtask

    // Memory model, all DUT inputs change on the falling edge
    always @(negedge clock) begin
        if (!rst_n) begin
            assert (dmem_wren === 1'b0) else begin
                reset_errs++;
                $display("Error: dmem_wren is high during reset at %0t", $time);
            end
        end else if (dmem_wren === 1'b1) begin
            check_store(dmem_addr, dmem_wdata);
            dmem[dmem_addr[7:0]] = dmem_wdata;   // Lands at the next rising edge
        end
        imem_data  = imem[imem_addr[7:0]];
        dmem_rdata = dmem[dmem_addr[7:0]];       // Ignored by the DUT unless a load
    end

    initial begin
        clock      = 1'b0;
        rst_n      = 1'b0;
        imem_data  = '0;
        dmem_rdata = '0;

        for (int i = 0; i < 256; i++) begin
            pat[i] = '0;
        end
        $readmemh("cpu_patterns.mem", pat);
        prog_len  = pat[0];
        exp_count = pat[prog_len + 1];
        exp_base  = prog_len + 2;
        assert (prog_len > 0 && prog_len < 200 && exp_count > 0) else begin
            file_errs++;
            $display("Error: pattern file is missing or its header is not valid");
        end

        // Unused words jump to themselves, a runaway PC parks there
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog_len) ? pat[i + 1] : (32'h0800_0000 | i);
            dmem[i] = {8'hd0, i[7:0], ~i[7:0], i[7:0] ^ 8'h96};
        end

        fork
            run_watchdog();
        join_none

        repeat (5) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        wait (store_cnt >= exp_count);
        repeat (20) @(negedge clock);          // Let the pipeline drain, catch extras
        assert (store_cnt == exp_count) else begin
            count_errs++;
            $display("Error: saw %0d stores where %0d were expected", store_cnt, exp_count);
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== cpu_patterns.mem ====
// Program length, then one instruction word per line, then the store count,
// then one expected store per line: address, data, test id
00000026
28400005 // 0  addi r1, r0, 5
28820003 // 1  addi r2, r1, 3
00c22000 // 2  add  r3, r1, r2
38c00010 // 3  sw   r3, 0x10(r0)
01061004 // 4  sub  r4, r3, r1
01480110 // 5  sll  r5, r4, 2
2981fff0 // 6  addi r6, r0, -16
01cc0114 // 7  sra  r7, r6, 2
02067008 // 8  and  r8, r3, r7
0250500c // 9  or   r9, r8, r5
3a400011 // 10 sw   r9, 0x11(r0)
39000012 // 11 sw   r4, 0x12(r0)
39400013 // 12 sw   r5, 0x13(r0)
39c00014 // 13 sw   r7, 0x14(r0)
3a000015 // 14 sw   r8, 0x15(r0)
42800010 // 15 lw   r10, 0x10(r0)
02d41000 // 16 add  r11, r10, r1
3ac00016 // 17 sw   r11, 0x16(r0)
4302000c // 18 lw   r12, 12(r1)
3b000017 // 19 sw   r12, 0x17(r0)
10440002 // 20 bne  r1, r2, +2 taken
3840001e // 21 sw   r1, 0x1e(r0) skipped
3880001f // 22 sw   r2, 0x1f(r0) skipped
31c20002 // 23 blt  r7 < r1, +2 taken
3840001e // 24 sw   r1, 0x1e(r0) skipped
3880001f // 25 sw   r2, 0x1f(r0) skipped
11040001 // 26 bne  r4, r2, +1 not taken
38400018 // 27 sw   r1, 0x18(r0)
30820001 // 28 blt  r2 < r1, +1 not taken
38800019 // 29 sw   r2, 0x19(r0)
08000020 // 30 j    32
3840001e // 31 sw   r1, 0x1e(r0) skipped
18000022 // 32 jal  34
3880001f // 33 sw   r2, 0x1f(r0) skipped
3fc0001a // 34 sw   r31, 0x1a(r0)
28000007 // 35 addi r0, r0, 7
3800001b // 36 sw   r0, 0x1b(r0)
08000025 // 37 j    37
0000000c
00000010 0000000d 1
00000011 0000002c 1
00000012 00000008 1
00000013 00000020 1
00000014 fffffffc 1
00000015 0000000c 1
00000016 00000012 2
00000017 0000002c 2
00000018 00000005 3
00000019 00000008 3
0000001a 00000021 4
0000001b 00000000 5

// ==== build.f ====
cpu_pkg.sv
alu.sv
register_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
cpu_top.sv
tb_cpu_top.sv
